// ==== rtl/tx_pkg.sv ====
package tx_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // word and nibble geometry
    ////////////////////////////////////////////////////////////////////////////

    // parallel word from the source
    localparam int word_w       = 16;
    // quarter-rate nibble width
    localparam int nib_w        = 4;
    localparam int nib_per_word = word_w / nib_w;
    localparam int nib_idx_w    = $clog2(nib_per_word);
    // bit position inside one nibble
    localparam int bit_cnt_w    = $clog2(nib_w);

    // word buffer, depth equals the initial credit count
    localparam int buf_depth    = 4;
    localparam int buf_ptr_w    = $clog2(buf_depth);
    localparam int buf_cnt_w    = $clog2(buf_depth + 1);

    // output skew, stands in for the PI code
    localparam int skew_w       = 2;
    localparam int skew_taps    = 1 << skew_w;

    // fill pattern when the buffer runs dry
    localparam logic [word_w-1:0] idle_word = '0;

    // source of the word currently on the wire
    typedef enum logic {
        hr_idle,
        hr_data
    } hr_state_t;

endpackage

// ==== rtl/tx_word_buffer.sv ====
`timescale 1ns/1ps

module tx_word_buffer import tx_pkg::*; (
    input  logic              mdll_clk,
    input  logic              reset,
    input  logic              cke,
    input  logic [word_w-1:0] din,
    input  logic              din_valid,
    input  logic              take,
    output logic [word_w-1:0] head_word,
    output logic              head_avail,
    output logic              credit
);

    // storage, no reset on the payload
    logic [word_w-1:0]    mem [buf_depth];
    logic [buf_ptr_w-1:0] wr_ptr;
    logic [buf_ptr_w-1:0] rd_ptr;
    // occupancy, 0 to buf_depth
    logic [buf_cnt_w-1:0] count;
    logic                 full;
    logic                 push;
    logic                 pop;

    assign full       = (count == buf_cnt_w'(buf_depth));
    assign head_avail = (count != '0);
    assign head_word  = mem[rd_ptr];

    // whole buffer freezes with cke low
    assign pop  = cke & take & head_avail;
    // a push into a full buffer only lands if a pop frees a slot
    assign push = cke & din_valid & (~full | pop);

    ////////////////////////////////////////////////////////////////////////////
    // pointers and occupancy
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge mdll_clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == buf_ptr_w'(buf_depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == buf_ptr_w'(buf_depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous push and pop leaves count alone
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge mdll_clk) begin
        if (push) begin
            mem[wr_ptr] <= din;
        end
    end

    // one credit back per word removed, one cycle after the pop
    always_ff @(posedge mdll_clk) begin
        if (reset) begin
            credit <= 1'b0;
        end else begin
            credit <= pop;
        end
    end

endmodule

// ==== rtl/hr_16t4_mux.sv ====
`timescale 1ns/1ps

module hr_16t4_mux import tx_pkg::*; (
    input  logic              mdll_clk,
    input  logic              reset,
    input  logic              cke,
    input  logic              invert,
    input  logic [word_w-1:0] head_word,
    input  logic              head_avail,
    input  logic              nib_load,
    output logic              word_take,
    output logic [nib_w-1:0]  nibble
);

    // held word, already complemented on the negative leg
    logic [word_w-1:0]    word_q;
    logic [word_w-1:0]    fill_word;
    logic [word_w-1:0]    word_sel;
    logic [nib_idx_w-1:0] nib_idx;
    logic                 last_nib;
    hr_state_t            state;

    // idle level of this leg
    assign fill_word = idle_word ^ {word_w{invert}};
    assign last_nib  = (nib_idx == nib_idx_w'(nib_per_word - 1));

    // pop only on the boundary that closes nibble 3
    assign word_take = cke & nib_load & last_nib & head_avail;

    ////////////////////////////////////////////////////////////////////////////
    // nibble index and word state
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge mdll_clk) begin
        if (reset) begin
            nib_idx <= '0;
            state   <= hr_idle;
        end else if (cke && nib_load) begin
            if (last_nib) begin
                nib_idx <= '0;
                // either a fresh word or idle fill for the next frame
                state   <= head_avail ? hr_data : hr_idle;
            end else begin
                nib_idx <= nib_idx + 1'b1;
            end
        end
    end

    // payload only changes on a take
    always_ff @(posedge mdll_clk) begin
        if (word_take) begin
            word_q <= head_word ^ {word_w{invert}};
        end
    end

    // idle frames bypass the held word
    assign word_sel = (state == hr_data) ? word_q : fill_word;
    assign nibble   = word_sel[nib_idx*nib_w +: nib_w];

endmodule

// ==== rtl/qr_4t1_mux.sv ====
`timescale 1ns/1ps

module qr_4t1_mux import tx_pkg::*; (
    input  logic             mdll_clk,
    input  logic             reset,
    input  logic             cke,
    input  logic [nib_w-1:0] nibble,
    output logic             nib_load,
    output logic             ser_bit
);

    // bit position within the current nibble
    logic [bit_cnt_w-1:0] bit_cnt;
    logic [nib_w-1:0]     shift_q;

    // last cycle of each nibble, acts as the divided clock for the word stage
    assign nib_load = (bit_cnt == bit_cnt_w'(nib_w - 1));

    ////////////////////////////////////////////////////////////////////////////
    // bit counter and shifter
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge mdll_clk) begin
        if (reset) begin
            bit_cnt <= '0;
        end else if (cke) begin
            // wraps 3 -> 0 with the word stage
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    // capture one cycle after the word stage has stepped its nibble
    always_ff @(posedge mdll_clk) begin
        if (reset) begin
            // park on the idle level presented by the word stage
            shift_q <= nibble;
        end else if (cke) begin
            if (bit_cnt == '0) begin
                shift_q <= nibble;
            end else begin
                // lsb first
                shift_q <= {shift_q[nib_w-1], shift_q[nib_w-1:1]};
            end
        end
    end

    assign ser_bit = shift_q[0];

endmodule

// ==== rtl/tx_skew_delay.sv ====
`timescale 1ns/1ps

module tx_skew_delay import tx_pkg::*; (
    input  logic              mdll_clk,
    input  logic              reset,
    input  logic              cke,
    input  logic [skew_w-1:0] ctl_pi,
    input  logic              ctl_valid,
    input  logic              ser_bit,
    output logic              dout
);

    // tap 0 is one cycle behind ser_bit
    logic [skew_taps-1:0] dly_q;
    // active skew code
    logic [skew_w-1:0]    code_q;

    ////////////////////////////////////////////////////////////////////////////
    // delay line
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge mdll_clk) begin
        if (reset) begin
            // flood with the leg's idle level
            dly_q <= {skew_taps{ser_bit}};
        end else if (cke) begin
            dly_q <= {dly_q[skew_taps-2:0], ser_bit};
        end
    end

    // new code only when qualified, like the PI ctl_valid
    always_ff @(posedge mdll_clk) begin
        if (reset) begin
            code_q <= '0;
        end else if (cke && ctl_valid) begin
            code_q <= ctl_pi;
        end
    end

    // tap select
    assign dout = dly_q[code_q];

endmodule

// ==== rtl/tx_top.sv ====
`timescale 1ns/1ps

module tx_top import tx_pkg::*; (
    input  logic              mdll_clk,
    input  logic              reset,
    input  logic [word_w-1:0] din,
    input  logic              din_valid,
    output logic              credit,
    input  logic              cke,
    input  logic [skew_w-1:0] ctl_pi,
    input  logic              ctl_valid,
    output logic              dout_p,
    output logic              dout_n
);

    // shared head of the word buffer
    logic [word_w-1:0] head_word;
    logic              head_avail;
    // pop strobe, positive leg only
    logic              word_take;

    // per-leg serializer nets
    logic [nib_w-1:0]  nibble_p;
    logic [nib_w-1:0]  nibble_n;
    logic              nib_load_p;
    logic              nib_load_n;
    logic              ser_bit_p;
    logic              ser_bit_n;

    tx_word_buffer u_buf (
        .mdll_clk, .reset, .cke, .din, .din_valid,
        .take       (word_take),
        .head_word, .head_avail, .credit
    );

    ////////////////////////////////////////////////////////////////////////////
    // positive leg
    ////////////////////////////////////////////////////////////////////////////

    hr_16t4_mux u_hr_p (
        .mdll_clk, .reset, .cke,
        .invert     (1'b0),
        .head_word, .head_avail,
        .nib_load   (nib_load_p),
        .word_take  (word_take),
        .nibble     (nibble_p)
    );

    qr_4t1_mux u_qr_p (
        .mdll_clk, .reset, .cke,
        .nibble     (nibble_p),
        .nib_load   (nib_load_p),
        .ser_bit    (ser_bit_p)
    );

    tx_skew_delay u_skew_p (
        .mdll_clk, .reset, .cke, .ctl_pi, .ctl_valid,
        .ser_bit    (ser_bit_p),
        .dout       (dout_p)
    );

    ////////////////////////////////////////////////////////////////////////////
    // negative leg, complemented word
    ////////////////////////////////////////////////////////////////////////////

    hr_16t4_mux u_hr_n (
        .mdll_clk, .reset, .cke,
        .invert     (1'b1),
        .head_word, .head_avail,
        .nib_load   (nib_load_n),
        // residue pop strobe, unused
        .word_take  (),
        .nibble     (nibble_n)
    );

    qr_4t1_mux u_qr_n (
        .mdll_clk, .reset, .cke,
        .nibble     (nibble_n),
        .nib_load   (nib_load_n),
        .ser_bit    (ser_bit_n)
    );

    tx_skew_delay u_skew_n (
        .mdll_clk, .reset, .cke, .ctl_pi, .ctl_valid,
        .ser_bit    (ser_bit_n),
        .dout       (dout_n)
    );

endmodule

// ==== dv/tx_props.sv ====
`timescale 1ns/1ps

module tx_props import tx_pkg::*; (
    input logic mdll_clk,
    input logic reset,
    input logic cke,
    input logic din_valid,
    input logic credit,
    input logic word_take,
    input logic dout_p,
    input logic dout_n
);

    // per-property failure tallies
    int unsigned full_errs = 0;
    int unsigned sym_errs = 0;
    int unsigned credit_errs = 0;
    int unsigned fail_count;

    // shadow of the buffer occupancy
    logic [buf_cnt_w-1:0] level;

    assign fail_count = full_errs + sym_errs + credit_errs;

    always_ff @(posedge mdll_clk) begin
        if (reset) begin
            level <= '0;
        end else begin
            case ({cke & din_valid, word_take})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // credit protocol and output symmetry
    ////////////////////////////////////////////////////////////////////////////

    // source may only write into a free slot
    no_full_write: assert property (@(posedge mdll_clk) disable iff (reset)
        (cke && din_valid) |-> (level < buf_cnt_w'(buf_depth)))
        else begin
            full_errs++;
            $error("word written while the buffer is full");
        end

    // legs stay complementary
    diff_symmetry: assert property (@(posedge mdll_clk) disable iff (reset)
        dout_n == !dout_p)
        else begin
            sym_errs++;
            $error("dout_n is not the complement of dout_p");
        end

    // pop then credit, one cycle apart
    credit_after_pop: assert property (@(posedge mdll_clk) disable iff (reset)
        word_take |=> credit)
        else begin
            credit_errs++;
            $error("no credit one cycle after a pop");
        end

    credit_has_pop: assert property (@(posedge mdll_clk) disable iff (reset)
        credit |-> $past(word_take))
        else begin
            credit_errs++;
            $error("credit pulse without a pop in the cycle before");
        end

endmodule

bind tx_top tx_props u_props (
    .mdll_clk, .reset, .cke, .din_valid, .credit, .word_take, .dout_p, .dout_n
);

// ==== dv/tx_tb.sv ====
`timescale 1ns/1ps

module tx_tb import tx_pkg::*; ();

    localparam int clk_period = 8;
    localparam int frame_len  = word_w;
    localparam int n_tests    = 8;
    localparam int max_words  = 64;
    // cke stall window in cycles from the start of a test
    localparam int stall_at   = 40;
    localparam int stall_len  = 9;
    // longest word plus max skew plus some slack
    localparam int drain_cyc  = 24;

    typedef struct packed {
        int                nwords;
        bit                rnd;
        logic [word_w-1:0] data;
        logic [skew_w-1:0] skew;
        bit                stall;
        int                gap;
    } test_t;

    // words, random, fixed data, skew, cke stall, cycles between sends
    test_t tests [n_tests] = '{
        '{1,  1'b0, 16'ha5c3, 2'd0, 1'b0, 1},
        '{12, 1'b1, 16'h0000, 2'd0, 1'b0, 1},
        '{5,  1'b1, 16'h0000, 2'd0, 1'b0, 40},
        '{4,  1'b1, 16'h0000, 2'd1, 1'b0, 1},
        '{4,  1'b1, 16'h0000, 2'd2, 1'b0, 20},
        '{4,  1'b1, 16'h0000, 2'd3, 1'b0, 1},
        '{6,  1'b1, 16'h0000, 2'd2, 1'b1, 1},
        '{3,  1'b0, 16'h8001, 2'd0, 1'b1, 1}
    };

    logic              mdll_clk = 1'b0;
    logic              reset;
    logic [word_w-1:0] din;
    logic              din_valid;
    logic              credit;
    logic              cke;
    logic [skew_w-1:0] ctl_pi;
    logic              ctl_valid;
    logic              dout_p;
    logic              dout_n;

    // source model tracks credits as buf_depth - sends + returns
    logic [word_w-1:0] sent_words [max_words];
    int                sends = 0;
    int                returns = 0;
    // expected dout_p keyed by count of enabled clock edges
    logic              exp_p [int];
    int                eff = 0;
    bit                adv = 1'b0;
    int                last_pop = 0;
    int                cur_skew = 0;
    int                cur_gap = 1;
    int                test_base = 0;
    int                err_cnt = 0;
    int                checks = 0;

    always #(clk_period / 2) mdll_clk = ~mdll_clk;

    tx_top dut (
        .mdll_clk, .reset, .din, .din_valid, .credit, .cke,
        .ctl_pi, .ctl_valid, .dout_p, .dout_n
    );

    task automatic compare_value(input string name, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
        checks++;
        if (act_v !== exp_v) begin
            err_cnt++;
            $display("MISMATCH t=%0t %s expected %0h actual %0h", $time, name, exp_v, act_v);
        end
    endtask

    task automatic flag_error(input string msg);
        err_cnt++;
        $display("ERROR t=%0t %s", $time, msg);
    endtask

    function automatic int test_frames(input test_t t);
        return t.nwords * ((t.gap + frame_len - 1) / frame_len + 1) + 4;
    endfunction

    function automatic int props_fails();
        return int'(dut.u_props.fail_count);
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // stream checker sampling mid-cycle
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge mdll_clk) begin
        logic              exp_bit;
        logic [word_w-1:0] w;
        bit                last_adv;
        last_adv = adv;
        if (reset) begin
            eff = 0;
        end else begin
            if (adv) begin
                eff++;
            end
            // credit marks the pop one edge back
            if (credit) begin
                if (!last_adv) begin
                    flag_error("credit returned while cke was low");
                end
                if (returns >= sends) begin
                    flag_error("credit returned with no word outstanding");
                end else begin
                    w = sent_words[returns];
                    compare_value("pop_phase", 32'(0), 32'(eff % frame_len));
                    if (cur_gap == 1 && returns > test_base) begin
                        compare_value("pop_interval", 32'(frame_len), 32'(eff - last_pop));
                    end
                    // bit j lands at pop + 2 + j + skew with lsb first
                    for (int j = 0; j < word_w; j++) begin
                        exp_p[eff + 2 + j + cur_skew] = w[j];
                    end
                    last_pop = eff;
                    returns++;
                end
            end
            // unscheduled cycles are idle fill
            exp_bit = exp_p.exists(eff) ? exp_p[eff] : 1'b0;
            compare_value("dout_p", 32'(exp_bit), 32'(dout_p));
            compare_value("dout_n", 32'(!exp_bit), 32'(dout_n));
        end
        // cke seen by the next rising edge
        adv = !reset && cke;
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        logic [word_w-1:0] w;
        int                gap_cnt;
        int                t_cyc;
        int                e0;
        int                n_fail;
        int                passed;
        bit                stall_now;
        void'($urandom(32'hdf34));
        passed    = 0;
        reset     = 1'b1;
        din       = '0;
        din_valid = 1'b0;
        cke       = 1'b1;
        ctl_pi    = '0;
        ctl_valid = 1'b0;
        repeat (5) @(posedge mdll_clk);
        reset <= 1'b0;
        for (int i = 0; i < n_tests; i++) begin
            e0 = err_cnt + props_fails();
            // qualified code followed by a decoy without ctl_valid
            @(posedge mdll_clk);
            cke       <= 1'b1;
            ctl_pi    <= tests[i].skew;
            ctl_valid <= 1'b1;
            @(posedge mdll_clk);
            ctl_valid <= 1'b0;
            ctl_pi    <= ~tests[i].skew;
            cur_skew  = int'(tests[i].skew);
            cur_gap   = tests[i].gap;
            test_base = sends;
            gap_cnt   = tests[i].gap;
            t_cyc     = 0;
            // run until every word is sent and its credit is back
            while (sends < test_base + tests[i].nwords || returns < sends) begin
                @(posedge mdll_clk);
                stall_now = tests[i].stall && t_cyc >= stall_at
                            && t_cyc < stall_at + stall_len;
                cke <= !stall_now;
                if (!stall_now && sends < test_base + tests[i].nwords
                        && sends - returns < buf_depth && gap_cnt >= tests[i].gap) begin
                    w = tests[i].rnd ? 16'($urandom()) : tests[i].data;
                    sent_words[sends] = w;
                    sends++;
                    din       <= w;
                    din_valid <= 1'b1;
                    gap_cnt = 1;
                end else begin
                    din_valid <= 1'b0;
                    gap_cnt++;
                end
                t_cyc++;
            end
            @(posedge mdll_clk);
            din_valid <= 1'b0;
            cke       <= 1'b1;
            repeat (drain_cyc) @(posedge mdll_clk);
            n_fail = err_cnt + props_fails() - e0;
            if (n_fail == 0) begin
                passed++;
            end
            $display("test %0d: %0d words, skew %0d, gap %0d, stall %0d, %s (%0d errors)",
                     i, tests[i].nwords, cur_skew, tests[i].gap, tests[i].stall,
                     (n_fail == 0) ? "ok" : "FAILED", n_fail);
        end
        $display("%0d tests, %0d passed, %0d checks, %0d errors, %0d assertion failures",
                 n_tests, passed, checks, err_cnt, props_fails());
        if (err_cnt + props_fails() == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // watchdog sized from the table
    initial begin
        int frames;
        frames = 10;
        for (int i = 0; i < n_tests; i++) begin
            frames += test_frames(tests[i]);
        end
        #(frames * frame_len * clk_period);
        $display("timeout: run did not finish within %0d frames", frames);
        $display("Test failures found");
        $finish;
    end

endmodule

// ==== compile.f ====
rtl/tx_pkg.sv
rtl/tx_word_buffer.sv
rtl/hr_16t4_mux.sv
rtl/qr_4t1_mux.sv
rtl/tx_skew_delay.sv
rtl/tx_top.sv
dv/tx_props.sv
dv/tx_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tx_tb
RTL_TOP   ?= tx_top
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+1000
FAIL_MSG  ?= Test failures found
PASS_MSG  ?= All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	-./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation incomplete"; exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
